// File: source/qd_cfg.svh
// Global widths for the decode stage; QD_RID_BITS above 6 shrinks the I and B fields of the word
`ifndef QD_CFG_SVH
`define QD_CFG_SVH

// ============================================================================
// Datapath widths
// ============================================================================

// Width of the decoded immediate after sign extension, 32 or 64
`define QD_IMM_BITS 32

// Architectural register id width, 6 gives 64 registers
// The instruction field layout in qdIsaPkg is derived from this value
`define QD_RID_BITS 6

// Fixed instruction word width of the ISA
`define QD_INSN_BITS 32

`endif

// File: source/qdIsaPkg.sv
// Instruction set description; field widths follow QD_RID_BITS and must all stay positive
`include "qd_cfg.svh"

package qdIsaPkg;

	// ========================================================================
	// Field widths
	// ========================================================================

	localparam int OPC_BITS  = 7;
	localparam int RID_BITS  = `QD_RID_BITS;
	localparam int REST_BITS = `QD_INSN_BITS - OPC_BITS;
	localparam int COND_BITS = 4;
	// Whatever is left over after the register fields of each format
	localparam int FUNC_BITS = REST_BITS - 3 * RID_BITS;
	localparam int IMM_BITS  = REST_BITS - 2 * RID_BITS;
	localparam int DISP_BITS = REST_BITS - COND_BITS - 2 * RID_BITS;

	// Opcodes known to the decoder, any other encoding is illegal
	typedef enum logic [OPC_BITS-1:0] {
		OP_NOP   = 7'h00,
		OP_ADD   = 7'h02,
		OP_ADDI  = 7'h04,
		OP_LOAD  = 7'h10,
		OP_STORE = 7'h18,
		OP_Bcc   = 7'h28,
		OP_BccU  = 7'h29,
		OP_ENTER = 7'h30,
		OP_LEAVE = 7'h31,
		OP_PUSH  = 7'h32,
		OP_POP   = 7'h33
	} opcode_e;

	// ========================================================================
	// Instruction word views, opcode always in the low bits
	// ========================================================================

	typedef struct packed {
		logic [REST_BITS-1:0] rest;
		opcode_e              opcode;
	} anyView_t;

	// Register format, also the base for I format rd and rs1
	typedef struct packed {
		logic [FUNC_BITS-1:0] func;
		logic [RID_BITS-1:0]  rs2;
		logic [RID_BITS-1:0]  rs1;
		logic [RID_BITS-1:0]  rd;
		opcode_e              opcode;
	} rView_t;

	typedef struct packed {
		logic [IMM_BITS-1:0] imm;
		logic [RID_BITS-1:0] rs1;
		logic [RID_BITS-1:0] rd;
		opcode_e             opcode;
	} iView_t;

	// Branch format, STORE reuses it with disp as offset and rs2 as data
	typedef struct packed {
		logic [DISP_BITS-1:0] disp;
		logic [RID_BITS-1:0]  rs2;
		logic [RID_BITS-1:0]  rs1;
		logic [COND_BITS-1:0] cond;
		opcode_e              opcode;
	} bView_t;

	typedef union packed {
		anyView_t any;
		rView_t   r;
		iView_t   i;
		bView_t   b;
	} instruction_t;

endpackage

// File: source/qdDecodePkg.sv
// Decode result types; the opcode field keeps the raw encoding even when it is illegal
`include "qd_cfg.svh"

package qdDecodePkg;

	// ========================================================================
	// Register specifiers
	// ========================================================================

	// Fields a format does not carry are zero
	typedef struct packed {
		logic [`QD_RID_BITS-1:0] rd;
		logic [`QD_RID_BITS-1:0] rs1;
		logic [`QD_RID_BITS-1:0] rs2;
		logic                    writesRd;
	} regFields_t;

	// ========================================================================
	// Decoded bundle handed to the next stage
	// ========================================================================

	typedef struct packed {
		qdIsaPkg::opcode_e       opcode;
		regFields_t              regs;
		logic [`QD_IMM_BITS-1:0] imm;
		logic                    hasImm;
		// Control transfer or macro sequencing, see qdDecodeBranch
		logic                    branch;
		logic                    isLoad;
		logic                    isStore;
		// Set alone, every other flag is clear for an unknown opcode
		logic                    illegal;
	} decoded_t;

endpackage

// File: source/qdDecodeBranch.sv
// Purely combinational; macro opcodes count as branches because they sequence the front end
module qdDecodeBranch
(
	input  qdIsaPkg::instruction_t instr,
	output logic                   branch
);

	// Conditional branches, signed and unsigned compare
	function automatic logic fnIsCondBranch(input qdIsaPkg::instruction_t ir);
		case (ir.any.opcode)
			qdIsaPkg::OP_Bcc, qdIsaPkg::OP_BccU: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// Macro instructions that the front end expands into sequences
	function automatic logic fnIsMacro(input qdIsaPkg::instruction_t ir);
		case (ir.any.opcode)
			qdIsaPkg::OP_ENTER,
			qdIsaPkg::OP_LEAVE,
			qdIsaPkg::OP_PUSH,
			qdIsaPkg::OP_POP: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// Either kind redirects fetch, so one flag covers both
	always_comb
	begin
		branch = fnIsCondBranch(instr) | fnIsMacro(instr);
	end

endmodule

// File: source/qdDecodeRegs.sv
// Purely combinational; register zero is hardwired, so rd of zero never counts as a write
module qdDecodeRegs
(
	input  qdIsaPkg::instruction_t  instr,
	output qdDecodePkg::regFields_t regs
);

	// Opcode class that targets a destination register
	logic hasRd;

	always_comb
	begin
		regs  = '0;
		hasRd = 1'b0;
		case (instr.any.opcode)
			// R format carries all three specifiers
			qdIsaPkg::OP_ADD:
			begin
				regs.rd  = instr.r.rd;
				regs.rs1 = instr.r.rs1;
				regs.rs2 = instr.r.rs2;
				hasRd    = 1'b1;
			end
			// I format shares rd and rs1 positions with R, no rs2
			qdIsaPkg::OP_ADDI, qdIsaPkg::OP_LOAD:
			begin
				regs.rd  = instr.r.rd;
				regs.rs1 = instr.r.rs1;
				hasRd    = 1'b1;
			end
			// B layout sits after the condition field, so take both sources from the B view
			// STORE reads its base from rs1 and its data from rs2
			qdIsaPkg::OP_Bcc, qdIsaPkg::OP_BccU, qdIsaPkg::OP_STORE:
			begin
				regs.rs1 = instr.b.rs1;
				regs.rs2 = instr.b.rs2;
			end
			// NOP, macros and illegal encodings carry no specifiers here
			default:
			begin
				hasRd = 1'b0;
			end
		endcase
		// Writes to register zero are dropped at decode
		regs.writesRd = hasRd && (regs.rd != '0);
	end

endmodule

// File: source/qdDecodeImm.sv
// Purely combinational; QD_IMM_BITS must be at least as wide as the I and B fields
`include "qd_cfg.svh"

module qdDecodeImm
(
	input  qdIsaPkg::instruction_t  instr,
	output logic [`QD_IMM_BITS-1:0] imm,
	output logic                    hasImm
);

	// ========================================================================
	// Sign extension of the two immediate fields
	// ========================================================================

	localparam int IW = qdIsaPkg::IMM_BITS;
	localparam int DW = qdIsaPkg::DISP_BITS;

	logic [`QD_IMM_BITS-1:0] immI;
	logic [`QD_IMM_BITS-1:0] immB;

	// Both candidates are formed every cycle, the opcode picks one below
	always_comb
	begin
		immI = {{(`QD_IMM_BITS - IW){instr.i.imm[IW-1]}}, instr.i.imm};
		immB = {{(`QD_IMM_BITS - DW){instr.b.disp[DW-1]}}, instr.b.disp};
	end

	// ========================================================================
	// Format selection
	// ========================================================================

	always_comb
	begin
		imm    = '0;
		hasImm = 1'b0;
		case (instr.any.opcode)
			qdIsaPkg::OP_ADDI, qdIsaPkg::OP_LOAD:
			begin
				imm    = immI;
				hasImm = 1'b1;
			end
			// Branch displacement and store offset share the B field
			qdIsaPkg::OP_Bcc, qdIsaPkg::OP_BccU, qdIsaPkg::OP_STORE:
			begin
				imm    = immB;
				hasImm = 1'b1;
			end
			default:
			begin
				hasImm = 1'b0;
			end
		endcase
	end

endmodule

// File: source/qdDecodeMerge.sv
// One cycle latency, no back-pressure; dec holds its last value while instrValid is low
`include "qd_cfg.svh"

module qdDecodeMerge
(
	input  logic                    clk,
	input  logic                    rstN,
	input  logic                    instrValid,
	input  qdIsaPkg::instruction_t  instr,
	input  logic                    branch,
	input  qdDecodePkg::regFields_t regs,
	input  logic [`QD_IMM_BITS-1:0] imm,
	input  logic                    hasImm,
	output logic                    decValid,
	output qdDecodePkg::decoded_t   dec
);

	qdDecodePkg::decoded_t nextDec;

	// ========================================================================
	// Opcode class and bundle assembly
	// ========================================================================

	always_comb
	begin
		nextDec         = '0;
		nextDec.opcode  = instr.any.opcode;
		nextDec.regs    = regs;
		nextDec.imm     = imm;
		nextDec.hasImm  = hasImm;
		nextDec.branch  = branch;
		case (instr.any.opcode)
			qdIsaPkg::OP_LOAD:  nextDec.isLoad  = 1'b1;
			qdIsaPkg::OP_STORE: nextDec.isStore = 1'b1;
			// Remaining known opcodes need no class flag here
			qdIsaPkg::OP_NOP, qdIsaPkg::OP_ADD, qdIsaPkg::OP_ADDI,
			qdIsaPkg::OP_Bcc, qdIsaPkg::OP_BccU,
			qdIsaPkg::OP_ENTER, qdIsaPkg::OP_LEAVE,
			qdIsaPkg::OP_PUSH, qdIsaPkg::OP_POP:
				nextDec.illegal = 1'b0;
			// Anything outside the enumeration, the sub-decoders already gave zeros
			default: nextDec.illegal = 1'b1;
		endcase
	end

	// ========================================================================
	// Output register
	// ========================================================================

	// decValid mirrors instrValid one edge later, the bundle loads only on valid
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			decValid <= 1'b0;
			dec      <= '0;
		end
		else
		begin
			decValid <= instrValid;
			if (instrValid)
				dec <= nextDec;
		end
	end

endmodule

// File: source/qdDecodeStage.sv
// Decode stage top; one word per cycle, fixed one-cycle latency, no ready or stall input
`include "qd_cfg.svh"

module qdDecodeStage
(
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   instrValid,
	input  qdIsaPkg::instruction_t instr,
	output logic                   decValid,
	output qdDecodePkg::decoded_t  dec
);

	// Combinational decoder results, all from the same word
	logic                    branch;
	qdDecodePkg::regFields_t regs;
	logic [`QD_IMM_BITS-1:0] imm;
	logic                    hasImm;

	qdDecodeBranch qdDecodeBranch_i
	(
		.instr  (instr),
		.branch (branch)
	);

	qdDecodeRegs qdDecodeRegs_i
	(
		.instr (instr),
		.regs  (regs)
	);

	qdDecodeImm qdDecodeImm_i
	(
		.instr  (instr),
		.imm    (imm),
		.hasImm (hasImm)
	);

	// Only the merge holds state and drives the stage outputs
	qdDecodeMerge qdDecodeMerge_i
	(
		.clk        (clk),
		.rstN       (rstN),
		.instrValid (instrValid),
		.instr      (instr),
		.branch     (branch),
		.regs       (regs),
		.imm        (imm),
		.hasImm     (hasImm),
		.decValid   (decValid),
		.dec        (dec)
	);

endmodule

// File: dv/qdDecode_assert.sv
// Bound into every qdDecodeStage; the checks assume a running clock and an asynchronous low reset
module qdDecodeAssert
(
	input logic                  clk,
	input logic                  rstN,
	input logic                  instrValid,
	input logic                  decValid,
	input qdDecodePkg::decoded_t dec
);

	// ========================================================================
	// Output protocol
	// ========================================================================

	// The first sampled cycle with reset released still shows the reset value
	resetRelease: assert property (@(posedge clk) $rose(rstN) |-> !decValid)
		else $error("decValid high in the first cycle after reset release");

	// Fixed one cycle latency, no stall
	validFollows: assert property (@(posedge clk) disable iff (!rstN)
		$past(rstN) |-> (decValid == $past(instrValid)))
		else $error("decValid does not follow instrValid of the previous cycle");

	// The bundle only loads on a valid word
	holdWhenIdle: assert property (@(posedge clk) disable iff (!rstN)
		!decValid |-> $stable(dec))
		else $error("dec changed while decValid was low");

	// An unknown opcode must not redirect fetch or write a register
	illegalAlone: assert property (@(posedge clk) disable iff (!rstN)
		dec.illegal |-> !(dec.branch || dec.regs.writesRd))
		else $error("illegal set together with branch or writesRd");

endmodule

bind qdDecodeStage qdDecodeAssert qdDecodeAssert_i
(
	.clk        (clk),
	.rstN       (rstN),
	.instrValid (instrValid),
	.decValid   (decValid),
	.dec        (dec)
);

// File: dv/qdDecodeTb.sv
// Vectors come from dv/qd_golden.hex, which holds values for the default 32-bit immediate and 6-bit ids
`include "qd_cfg.svh"

module qdDecodeTb;

	// Expected decode of one golden line; the opcode is taken from the word itself
	typedef struct packed {
		logic                    branch;
		logic                    writesRd;
		logic [`QD_RID_BITS-1:0] rd;
		logic [`QD_RID_BITS-1:0] rs1;
		logic [`QD_RID_BITS-1:0] rs2;
		logic                    hasImm;
		logic [`QD_IMM_BITS-1:0] imm;
		logic                    isLoad;
		logic                    isStore;
		logic                    illegal;
	} expect_t;

	// One golden line with the input side and its expectation
	typedef struct packed {
		logic        valid;
		logic [31:0] word;
		expect_t     exp;
	} vector_t;

	// Longest random idle gap inserted before a vector
	localparam int MAX_GAP = 3;

	logic                   clk;
	logic                   rstN;
	logic                   instrValid;
	qdIsaPkg::instruction_t instr;
	logic                   decValid;
	qdDecodePkg::decoded_t  dec;

	vector_t               vectors[$];
	vector_t               curVec;
	vector_t               heldVec;
	logic                  heldValid;
	qdDecodePkg::decoded_t lastDec;
	int                    cycleLimit;
	int                    cycles;

	qdDecodeStage qdDecodeStage_i
	(
		.clk        (clk),
		.rstN       (rstN),
		.instrValid (instrValid),
		.instr      (instr),
		.decValid   (decValid),
		.dec        (dec)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ========================================================================
	// Failure reporting and comparison
	// ========================================================================

	task automatic abortRun();
		$display("TEST FAIL");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic compareField(input string name, input logic [63:0] got,
		input logic [63:0] want);
		assert (got === want)
		else
		begin
			$display("error: %s got 0x%0h expected 0x%0h", name, got, want);
			abortRun();
		end
	endtask

	// Mostly zero, so that many words run back to back
	function automatic int pickGap();
		int unsigned r;
		r = $urandom % 8;
		return (r > 4) ? int'(r - 4) : 0;
	endfunction

	// ========================================================================
	// Golden file
	// ========================================================================

	// Lines starting with # are column notes, every other line carries twelve hex columns
	task automatic loadGolden(output bit ok);
		int                      fd;
		int                      n;
		string                   line;
		logic [31:0]             tValid, tWord, tBr, tWr, tRd, tRs1, tRs2, tHas;
		logic [31:0]             tLoad, tStore, tIll;
		logic [`QD_IMM_BITS-1:0] tImm;
		vector_t                 v;
		ok = 1'b1;
		fd = $fopen("dv/qd_golden.hex", "r");
		if (fd == 0)
			ok = 1'b0;
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				if (line.len() > 1 && line.getc(0) != "#")
				begin
					n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", tValid, tWord,
						tBr, tWr, tRd, tRs1, tRs2, tHas, tImm, tLoad, tStore, tIll);
					if (n != 12)
						ok = 1'b0;
					v.valid        = tValid[0];
					v.word         = tWord;
					v.exp.branch   = tBr[0];
					v.exp.writesRd = tWr[0];
					v.exp.rd       = tRd[`QD_RID_BITS-1:0];
					v.exp.rs1      = tRs1[`QD_RID_BITS-1:0];
					v.exp.rs2      = tRs2[`QD_RID_BITS-1:0];
					v.exp.hasImm   = tHas[0];
					v.exp.imm      = tImm;
					v.exp.isLoad   = tLoad[0];
					v.exp.isStore  = tStore[0];
					v.exp.illegal  = tIll[0];
					vectors.push_back(v);
				end
			end
			$fclose(fd);
		end
	endtask

	// ========================================================================
	// The output checker runs on the falling edge where all outputs are settled
	// ========================================================================

	// Whatever was on the inputs at this falling edge is sampled at the next rising edge
	// and must show up on the outputs by the falling edge after that
	always @(negedge clk)
	begin
		if (rstN)
		begin
			if (heldValid)
			begin
				compareField("decValid", 64'(decValid), 64'(1'b1));
				compareField("dec.opcode", 64'(dec.opcode), 64'(heldVec.word[6:0]));
				compareField("dec.branch", 64'(dec.branch), 64'(heldVec.exp.branch));
				compareField("dec.regs.writesRd", 64'(dec.regs.writesRd),
					64'(heldVec.exp.writesRd));
				compareField("dec.regs.rd", 64'(dec.regs.rd), 64'(heldVec.exp.rd));
				compareField("dec.regs.rs1", 64'(dec.regs.rs1), 64'(heldVec.exp.rs1));
				compareField("dec.regs.rs2", 64'(dec.regs.rs2), 64'(heldVec.exp.rs2));
				compareField("dec.hasImm", 64'(dec.hasImm), 64'(heldVec.exp.hasImm));
				compareField("dec.imm", 64'(dec.imm), 64'(heldVec.exp.imm));
				compareField("dec.isLoad", 64'(dec.isLoad), 64'(heldVec.exp.isLoad));
				compareField("dec.isStore", 64'(dec.isStore), 64'(heldVec.exp.isStore));
				compareField("dec.illegal", 64'(dec.illegal), 64'(heldVec.exp.illegal));
			end
			else
			begin
				// Idle cycles include the ones right after reset where dec is still zero
				compareField("decValid", 64'(decValid), 64'(1'b0));
				assert (dec === lastDec)
				else
				begin
					$display("error: dec got 0x%0h expected 0x%0h", dec, lastDec);
					abortRun();
				end
			end
			lastDec   = dec;
			heldValid = instrValid;
			heldVec   = curVec;
		end
	end

	// ========================================================================
	// Stimulus
	// ========================================================================

	initial
	begin
		bit ok;
		int gap;
		rstN       = 1'b0;
		instrValid = 1'b0;
		instr      = '0;
		curVec     = '0;
		heldVec    = '0;
		heldValid  = 1'b0;
		lastDec    = '0;
		cycleLimit = 0;
		void'($urandom(32'h7249_3735));
		loadGolden(ok);
		if (!ok)
		begin
			$display("golden file dv/qd_golden.hex is missing or has a malformed line");
			abortRun();
		end
		else
		begin
			// Reset, then every vector with its longest gap, then some drain time
			cycleLimit = 16 + vectors.size() * (1 + MAX_GAP) + 20;
			repeat (16) @(posedge clk);
			rstN <= 1'b1;
			foreach (vectors[k])
			begin
				gap = pickGap();
				repeat (gap)
				begin
					@(posedge clk);
					instrValid <= 1'b0;
				end
				@(posedge clk);
				instrValid <= vectors[k].valid;
				instr      <= qdIsaPkg::instruction_t'(vectors[k].word);
				curVec     <= vectors[k];
			end
			@(posedge clk);
			instrValid <= 1'b0;
			repeat (3) @(posedge clk);
			$display("TEST PASS");
			$finish;
		end
	end

	// Cycle counter that ends a run which never reaches its last check
	initial
	begin
		cycles = 0;
		while (cycleLimit == 0 || cycles < cycleLimit)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", cycleLimit);
		abortRun();
	end

endmodule

// File: dv/qd_golden.hex
# valid word branch writesRd rd rs1 rs2 hasImm imm isLoad isStore illegal, all in hex
# rows with valid 0 are idle cycles, their expected columns are not used
1 00288182 0 1 03 04 05 0 00000000 0 0 0
1 FE102002 0 0 00 01 02 0 00000000 0 0 0
1 7FF84084 0 1 01 02 00 1 00000FFF 0 0 0
1 80001F84 0 1 3F 00 00 1 FFFFF000 0 0 0
1 FFF96510 0 1 0A 0B 00 1 FFFFFFFF 1 0 0
0 00288182 0 0 00 00 00 0 00000000 0 0 0
1 7FF8A010 0 0 00 05 00 1 00000FFF 1 0 0
1 0080E004 0 0 00 07 00 1 00000010 0 0 0
1 7F8610A8 1 0 00 02 03 1 000000FF 0 0 0
1 807FFFA8 1 0 00 3F 3F 1 FFFFFF00 0 0 0
1 FF8A2129 1 0 00 04 05 1 FFFFFFFF 0 0 0
1 00800829 1 0 00 01 00 1 00000001 0 0 0
1 F80E3018 0 0 00 06 07 1 FFFFFFF0 0 1 0
1 12345630 1 0 00 00 00 0 00000000 0 0 0
1 00000031 1 0 00 00 00 0 00000000 0 0 0
1 00000132 1 0 00 00 00 0 00000000 0 0 0
1 ABCDEF33 1 0 00 00 00 0 00000000 0 0 0
1 00000000 0 0 00 00 00 0 00000000 0 0 0
1 FFFFFF00 0 0 00 00 00 0 00000000 0 0 0
1 0000007F 0 0 00 00 00 0 00000000 0 0 1
1 00288181 0 0 00 00 00 0 00000000 0 0 1
0 FFFFFFFF 0 0 00 00 00 0 00000000 0 0 0
1 12345691 0 0 00 00 00 0 00000000 0 0 1
1 00288182 0 1 03 04 05 0 00000000 0 0 0

// File: tb.f
+incdir+source
source/qdIsaPkg.sv
source/qdDecodePkg.sv
source/qdDecodeBranch.sv
source/qdDecodeRegs.sv
source/qdDecodeImm.sv
source/qdDecodeMerge.sv
source/qdDecodeStage.sv
dv/qdDecode_assert.sv
dv/qdDecodeTb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f tb.f --top-module qdDecodeTb || { echo "build failed"; exit 1; }
out="$(./obj_dir/VqdDecodeTb 2>&1)"
echo "$out"
echo "$out" | grep -qx "TEST PASS" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
